// ==== cft_pkg.sv ====
package cft_pkg;

   ////////////////////////////////////////
   // Widths and plain vector types
   ////////////////////////////////////////

   // Default width of the completed-cycle counter
   localparam int CYCLE_COUNT_WIDTH = 16;

   typedef logic [4:0]                   reg_addr_t;
   typedef logic [15:0]                  word_t;
   typedef logic [7:0]                   byte_t;
   // Counter at the default width
   typedef logic [CYCLE_COUNT_WIDTH-1:0] cycle_count_t;

   // Flag register, fi in the top bit
   typedef struct packed {
      logic fi;
      logic fv;
      logic fl;
      logic fz;
      logic fn;
   } flags_t;

   // ALU side of the flag update
   typedef struct packed {
      word_t result;
      // Link bit out of the ALU
      logic  carry;
      logic  overflow;
      // Request for a flag update at the end of T4
      logic  we;
   } alu_flags_t;

   typedef enum logic [1:0] {
      T1 = 2'd0,
      T2 = 2'd1,
      T3 = 2'd2,
      T4 = 2'd3
   } phase_t;

   typedef enum logic [1:0] {
      STOPPED  = 2'd0,
      RUNNING  = 2'd1,
      STEPPING = 2'd2
   } run_state_t;

   ////////////////////////////////////////
   // Microcode register addresses
   ////////////////////////////////////////

   localparam reg_addr_t ADDR_MBP_FLAGS = 5'd13;
   localparam reg_addr_t ADDR_FLAGS     = 5'd14;
   // Write side only
   localparam reg_addr_t ADDR_IR        = 5'd15;
   // Read side only
   localparam reg_addr_t ADDR_AGL       = 5'd15;

   ////////////////////////////////////////
   // Flag bitmap layout
   ////////////////////////////////////////

   // Same layout on the high bus byte and on the panel lights
   localparam int BIT_FI = 7;
   localparam int BIT_FV = 5;
   localparam int BIT_FL = 4;
   localparam int BIT_FZ = 3;
   localparam int BIT_FN = 2;

   // Bitmap bit n sits on bus bit n + 8
   localparam int BUS_HI_LSB = 8;

   // Reserved bit 6 and bits 1..0 read as zero
   function automatic byte_t flag_bitmap(input flags_t f);
      byte_t b;
      b         = '0;
      b[BIT_FI] = f.fi;
      b[BIT_FV] = f.fv;
      b[BIT_FL] = f.fl;
      b[BIT_FZ] = f.fz;
      b[BIT_FN] = f.fn;
      return b;
   endfunction

endpackage

// ==== cycle_control_fsm.sv ====
`timescale 1ns/1ns

module cycle_control_fsm (
   input  logic clk,
   input  logic reset,
   // Level, keeps cycles going
   input  logic run,
   // One-clock request for a single cycle
   input  logic step,
   // High during an active T4
   input  logic end_of_cycle,
   output logic cycle_active
);

   cft_pkg::run_state_t state;
   cft_pkg::run_state_t state_next;

   ////////////////////////////////////////
   // Next state
   ////////////////////////////////////////

   always_comb begin
      state_next = state;
      case (state)
         cft_pkg::STOPPED: begin
            // Run wins over a step in the same clock
            if (run) begin
               state_next = cft_pkg::RUNNING;
            end else if (step) begin
               state_next = cft_pkg::STEPPING;
            end
         end
         cft_pkg::RUNNING: begin
            // Dropping run only takes effect on a cycle boundary
            if (!run && end_of_cycle) begin
               state_next = cft_pkg::STOPPED;
            end
         end
         cft_pkg::STEPPING: begin
            // One T1..T4 cycle, then back to stopped
            if (end_of_cycle) begin
               state_next = cft_pkg::STOPPED;
            end
         end
         default: begin
            state_next = cft_pkg::STOPPED;
         end
      endcase
   end

   ////////////////////////////////////////
   // State register
   ////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (reset) begin
         state <= cft_pkg::STOPPED;
      end else begin
         state <= state_next;
      end
   end

   // Phases advance in both running and stepping
   assign cycle_active = (state != cft_pkg::STOPPED);

endmodule

// ==== phase_timer.sv ====
`timescale 1ns/1ns

module phase_timer #(
   parameter int CYCLE_COUNT_WIDTH = cft_pkg::CYCLE_COUNT_WIDTH
) (
   input  logic                         clk,
   input  logic                         reset,
   input  logic                         cycle_active,
   output cft_pkg::phase_t              phase,
   // Last clock of an active cycle
   output logic                         end_of_cycle,
   // Completed processor cycles, for the panel
   output logic [CYCLE_COUNT_WIDTH-1:0] cycle_count
);

   cft_pkg::phase_t phase_next;

   // Phase sequence T1 -> T2 -> T3 -> T4 -> T1
   always_comb begin
      case (phase)
         cft_pkg::T1: phase_next = cft_pkg::T2;
         cft_pkg::T2: phase_next = cft_pkg::T3;
         cft_pkg::T3: phase_next = cft_pkg::T4;
         default:     phase_next = cft_pkg::T1;
      endcase
   end

   assign end_of_cycle = cycle_active && (phase == cft_pkg::T4);

   always_ff @(posedge clk) begin
      if (reset) begin
         phase       <= cft_pkg::T1;
         cycle_count <= '0;
      end else if (cycle_active) begin
         // Phase holds while stopped
         phase <= phase_next;
         if (end_of_cycle) begin
            cycle_count <= cycle_count + 1'b1;
         end
      end
   end

endmodule

// ==== flag_unit.sv ====
`timescale 1ns/1ns

module flag_unit (
   input  cft_pkg::reg_addr_t waddr,
   input  cft_pkg::reg_addr_t raddr,
   input  cft_pkg::phase_t    phase,
   input  logic               cycle_active,
   input  cft_pkg::flags_t    flags,
   // Level that lights the panel flag section
   input  logic               fp_flags_en,
   // Write strobes, active T4 only
   output logic               flag_we,
   output logic               write_ir,
   output logic               read_agl,
   // High byte of the internal bus
   output cft_pkg::byte_t     ibus_hi,
   output logic               ibus_hi_drive,
   // Front-panel lights
   output cft_pkg::byte_t     fpd
);

   logic [7:0]     wy;
   logic [7:0]     ry;
   logic           t4_active;
   logic           write_flags;
   cft_pkg::byte_t bitmap;

   ////////////////////////////////////////
   // Address decode
   ////////////////////////////////////////

   // 3-to-8 demux, bit 3 enables, bit 4 inhibits
   function automatic logic [7:0] decode_138(input cft_pkg::reg_addr_t addr);
      logic [7:0] y;
      y = '0;
      if (addr[3] && !addr[4]) begin
         y[addr[2:0]] = 1'b1;
      end
      return y;
   endfunction

   assign wy = decode_138(waddr);
   assign ry = decode_138(raddr);

   ////////////////////////////////////////
   // Write side
   ////////////////////////////////////////

   // Writes only happen in the last phase of a live cycle
   assign t4_active = cycle_active && (phase == cft_pkg::T4);

   // Both flag addresses load the same register
   assign write_flags = wy[cft_pkg::ADDR_MBP_FLAGS[2:0]] | wy[cft_pkg::ADDR_FLAGS[2:0]];

   assign flag_we  = write_flags & t4_active;
   assign write_ir = wy[cft_pkg::ADDR_IR[2:0]] & t4_active;

   ////////////////////////////////////////
   // Read side
   ////////////////////////////////////////

   assign bitmap = cft_pkg::flag_bitmap(flags);

   assign ibus_hi_drive = ry[cft_pkg::ADDR_MBP_FLAGS[2:0]] | ry[cft_pkg::ADDR_FLAGS[2:0]];
   // Bus byte is zero when not driving
   assign ibus_hi       = ibus_hi_drive ? bitmap : '0;

   // AGL lives elsewhere, only the strobe is made here
   assign read_agl = ry[cft_pkg::ADDR_AGL[2:0]];

   // Panel shows the bus layout, dark when disabled
   assign fpd = fp_flags_en ? bitmap : '0;

endmodule

// ==== flag_register.sv ====
`timescale 1ns/1ns

module flag_register (
   input  logic                clk,
   input  logic                reset,
   // Bus write, already gated to an active T4
   input  logic                flag_we,
   input  cft_pkg::phase_t     phase,
   input  logic                cycle_active,
   input  cft_pkg::word_t      bus_in,
   input  cft_pkg::alu_flags_t alu,
   output cft_pkg::flags_t     flags
);

   logic end_of_t4;
   logic alu_update;
   logic result_zero;
   logic result_sign;

   ////////////////////////////////////////
   // Update conditions
   ////////////////////////////////////////

   assign end_of_t4 = cycle_active && (phase == cft_pkg::T4);

   // ALU loses to a bus write in the same cycle
   assign alu_update = end_of_t4 && alu.we && !flag_we;

   assign result_zero = (alu.result == '0);
   assign result_sign = alu.result[$bits(cft_pkg::word_t)-1];

   ////////////////////////////////////////
   // Flag storage
   ////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (reset) begin
         flags <= '0;
      end else if (flag_we) begin
         // Only FI, FV and FL are writable from the bus
         flags.fi <= bus_in[cft_pkg::BUS_HI_LSB + cft_pkg::BIT_FI];
         flags.fv <= bus_in[cft_pkg::BUS_HI_LSB + cft_pkg::BIT_FV];
         flags.fl <= bus_in[cft_pkg::BUS_HI_LSB + cft_pkg::BIT_FL];
      end else if (alu_update) begin
         // FI belongs to the interrupt logic, left alone
         flags.fz <= result_zero;
         flags.fn <= result_sign;
         flags.fl <= alu.carry;
         flags.fv <= alu.overflow;
      end
   end

endmodule

// ==== cft_flag_top.sv ====
`timescale 1ns/1ns

module cft_flag_top #(
   parameter int CYCLE_COUNT_WIDTH = cft_pkg::CYCLE_COUNT_WIDTH
) (
   input  logic                         clk,
   input  logic                         reset,
   // Front-panel controls
   input  logic                         run,
   input  logic                         step,
   // Microcode addresses, stable for a whole cycle
   input  cft_pkg::reg_addr_t           waddr,
   input  cft_pkg::reg_addr_t           raddr,
   input  cft_pkg::word_t               bus_in,
   input  cft_pkg::alu_flags_t          alu,
   input  logic                         fp_flags_en,
   // Cycle machinery
   output cft_pkg::phase_t              phase,
   output logic                         cycle_active,
   output logic [CYCLE_COUNT_WIDTH-1:0] cycle_count,
   // Flag state and its views
   output cft_pkg::flags_t              flags,
   output cft_pkg::byte_t               ibus_hi,
   output logic                         ibus_hi_drive,
   output cft_pkg::byte_t               fpd,
   // Strobes
   output logic                         flag_we,
   output logic                         write_ir,
   output logic                         read_agl
);

   logic end_of_cycle;

   ////////////////////////////////////////
   // Processor cycle control
   ////////////////////////////////////////

   cycle_control_fsm cycle_control_fsm_i (
      .clk          (clk),
      .reset        (reset),
      .run          (run),
      .step         (step),
      .end_of_cycle (end_of_cycle),
      .cycle_active (cycle_active)
   );

   phase_timer #(
      .CYCLE_COUNT_WIDTH (CYCLE_COUNT_WIDTH)
   ) phase_timer_i (
      .clk          (clk),
      .reset        (reset),
      .cycle_active (cycle_active),
      .phase        (phase),
      .end_of_cycle (end_of_cycle),
      .cycle_count  (cycle_count)
   );

   ////////////////////////////////////////
   // Flag section
   ////////////////////////////////////////

   flag_unit flag_unit_i (
      .waddr         (waddr),
      .raddr         (raddr),
      .phase         (phase),
      .cycle_active  (cycle_active),
      .flags         (flags),
      .fp_flags_en   (fp_flags_en),
      .flag_we       (flag_we),
      .write_ir      (write_ir),
      .read_agl      (read_agl),
      .ibus_hi       (ibus_hi),
      .ibus_hi_drive (ibus_hi_drive),
      .fpd           (fpd)
   );

   // Loads on the edge that closes an active T4
   flag_register flag_register_i (
      .clk          (clk),
      .reset        (reset),
      .flag_we      (flag_we),
      .phase        (phase),
      .cycle_active (cycle_active),
      .bus_in       (bus_in),
      .alu          (alu),
      .flags        (flags)
   );

endmodule

// ==== tb_cft_flag_top.sv ====
`timescale 1ns/1ns

module tb_cft_flag_top;

   localparam int CLK_PERIOD        = 4;
   localparam int RESET_CYCLES      = 5;
   localparam int COUNT_WIDTH       = 12;
   // Two setup clocks, four active clocks, two idle clocks
   localparam int CLOCKS_PER_VECTOR = 8;

   // One line of the vector file
   typedef struct packed {
      logic                is_step;
      cft_pkg::reg_addr_t  waddr;
      cft_pkg::reg_addr_t  raddr;
      cft_pkg::word_t      bus_in;
      cft_pkg::alu_flags_t alu;
      logic                fp_en;
      cft_pkg::flags_t     exp_flags;
      logic                exp_drive;
      cft_pkg::byte_t      exp_ibus_hi;
      logic                exp_write_ir;
      logic                exp_read_agl;
   } vector_t;

   logic                   clk;
   logic                   reset;
   logic                   run;
   logic                   step;
   cft_pkg::reg_addr_t     waddr;
   cft_pkg::reg_addr_t     raddr;
   cft_pkg::word_t         bus_in;
   cft_pkg::alu_flags_t    alu;
   logic                   fp_flags_en;
   cft_pkg::phase_t        phase;
   logic                   cycle_active;
   logic [COUNT_WIDTH-1:0] cycle_count;
   cft_pkg::flags_t        flags;
   cft_pkg::byte_t         ibus_hi;
   logic                   ibus_hi_drive;
   cft_pkg::byte_t         fpd;
   logic                   flag_we;
   logic                   write_ir;
   logic                   read_agl;

   vector_t vec_q[$];
   int      error_count    = 0;
   int      failed_vectors = 0;
   int      limit_ns       = 0;
   logic    vectors_loaded = 1'b0;

   cft_flag_top #(
      .CYCLE_COUNT_WIDTH (COUNT_WIDTH)
   ) cft_flag_top_i (
      .clk           (clk),
      .reset         (reset),
      .run           (run),
      .step          (step),
      .waddr         (waddr),
      .raddr         (raddr),
      .bus_in        (bus_in),
      .alu           (alu),
      .fp_flags_en   (fp_flags_en),
      .phase         (phase),
      .cycle_active  (cycle_active),
      .cycle_count   (cycle_count),
      .flags         (flags),
      .ibus_hi       (ibus_hi),
      .ibus_hi_drive (ibus_hi_drive),
      .fpd           (fpd),
      .flag_we       (flag_we),
      .write_ir      (write_ir),
      .read_agl      (read_agl)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   ////////////////////////////////////////
   // Helpers
   ////////////////////////////////////////

   task automatic check_value(input string what, input logic [31:0] got,
                              input logic [31:0] expected);
      if (got !== expected) begin
         error_count++;
         $display("error at %0t ns: %s is %0h, expected %0h", $time, what, got, expected);
      end
   endtask

   // Bitmap with fi on top and bit 6 and bits 1..0 dark
   function automatic cft_pkg::byte_t flags_to_bitmap(input cft_pkg::flags_t f);
      return {f.fi, 1'b0, f.fv, f.fl, f.fz, f.fn, 2'b00};
   endfunction

   task automatic load_vectors();
      int                 fd;
      int                 n;
      logic [8*8-1:0]     tok;
      logic [8*256-1:0]   rest_of_line;
      logic [31:0]        c [0:12];
      vector_t            v;
      fd = $fopen("cft_flag_testdata.txt", "r");
      if (fd == 0) begin
         $display("could not open the vector file cft_flag_testdata.txt");
         error_count++;
      end else begin
         n = $fscanf(fd, "%s", tok);
         while (n == 1) begin
            if (tok == "#") begin
               // Column description line is skipped whole
               n = $fgets(rest_of_line, fd);
            end else begin
               n = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h %h %h", c[0], c[1], c[2],
                           c[3], c[4], c[5], c[6], c[7], c[8], c[9], c[10], c[11], c[12]);
               if (n != 13) begin
                  $display("malformed line in the vector file after %0d vectors", vec_q.size());
                  error_count++;
               end else begin
                  v.is_step      = (tok == "step");
                  v.waddr        = c[0];
                  v.raddr        = c[1];
                  v.bus_in       = c[2];
                  v.alu.result   = c[3];
                  v.alu.carry    = c[4][0];
                  v.alu.overflow = c[5][0];
                  v.alu.we       = c[6][0];
                  v.fp_en        = c[7][0];
                  v.exp_flags    = c[8];
                  v.exp_drive    = c[9][0];
                  v.exp_ibus_hi  = c[10];
                  v.exp_write_ir = c[11][0];
                  v.exp_read_agl = c[12][0];
                  vec_q.push_back(v);
               end
            end
            n = (n > 0) ? $fscanf(fd, "%s", tok) : 0;
         end
         $fclose(fd);
      end
   endtask

   ////////////////////////////////////////
   // One processor cycle per vector
   ////////////////////////////////////////

   task automatic run_vector(input int idx, input vector_t v);
      int                     errors_before;
      int                     active_clocks;
      logic [COUNT_WIDTH-1:0] count_before;
      logic                   exp_flag_we;
      logic                   in_t4;
      cft_pkg::byte_t         exp_bitmap;
      errors_before = error_count;
      active_clocks = 0;
      exp_flag_we   = (v.waddr == cft_pkg::ADDR_MBP_FLAGS) || (v.waddr == cft_pkg::ADDR_FLAGS);
      exp_bitmap    = flags_to_bitmap(v.exp_flags);
      @(negedge clk);
      count_before = cycle_count;
      // Inputs go on at T1 together with the start request
      @(posedge clk);
      waddr       <= v.waddr;
      raddr       <= v.raddr;
      bus_in      <= v.bus_in;
      alu         <= v.alu;
      fp_flags_en <= v.fp_en;
      if (v.is_step) begin
         step <= 1'b1;
      end else begin
         run <= 1'b1;
      end
      // FSM takes the request on this edge
      // Step lasts one clock and run drops at once
      @(posedge clk);
      step <= 1'b0;
      run  <= 1'b0;
      @(negedge clk);
      while (cycle_active && active_clocks < CLOCKS_PER_VECTOR) begin
         // Fourth active clock of the cycle is T4
         in_t4 = (active_clocks == 3);
         check_value("phase", phase, active_clocks);
         check_value("flag_we", flag_we, exp_flag_we && in_t4);
         check_value("write_ir", write_ir, v.exp_write_ir && in_t4);
         check_value("read_agl", read_agl, v.exp_read_agl);
         check_value("ibus_hi_drive", ibus_hi_drive, v.exp_drive);
         active_clocks++;
         @(negedge clk);
      end
      // Flags now hold the T4 result
      check_value("active clocks", active_clocks, 4);
      check_value("phase after cycle", phase, cft_pkg::T1);
      check_value("cycle_count", cycle_count, count_before + 1);
      check_value("flags", flags, v.exp_flags);
      check_value("ibus_hi_drive after cycle", ibus_hi_drive, v.exp_drive);
      check_value("ibus_hi", ibus_hi, v.exp_ibus_hi);
      check_value("ibus_hi bitmap", ibus_hi, v.exp_drive ? exp_bitmap : 8'h00);
      check_value("fpd", fpd, v.fp_en ? exp_bitmap : 8'h00);
      // Stopped machine stays put
      repeat (2) @(negedge clk);
      check_value("cycle_active when stopped", cycle_active, 1'b0);
      check_value("phase when stopped", phase, cft_pkg::T1);
      check_value("cycle_count when stopped", cycle_count, count_before + 1);
      check_value("flags when stopped", flags, v.exp_flags);
      check_value("flag_we when stopped", flag_we, 1'b0);
      check_value("write_ir when stopped", write_ir, 1'b0);
      if (error_count == errors_before) begin
         $display("vector %0d (%s waddr %h raddr %h): ok", idx,
                  v.is_step ? "step" : "run", v.waddr, v.raddr);
      end else begin
         failed_vectors++;
         $display("vector %0d (%s waddr %h raddr %h): %0d mismatches", idx,
                  v.is_step ? "step" : "run", v.waddr, v.raddr, error_count - errors_before);
      end
   endtask

   ////////////////////////////////////////
   // Main sequence and watchdog
   ////////////////////////////////////////

   initial begin
      reset       = 1'b1;
      run         = 1'b0;
      step        = 1'b0;
      waddr       = '0;
      raddr       = '0;
      bus_in      = '0;
      alu         = '0;
      fp_flags_en = 1'b0;
      load_vectors();
      limit_ns = (RESET_CYCLES + vec_q.size() * CLOCKS_PER_VECTOR * 2 + 50) * CLK_PERIOD;
      vectors_loaded = 1'b1;
      repeat (RESET_CYCLES) @(posedge clk);
      reset <= 1'b0;
      for (int i = 0; i < vec_q.size(); i++) begin
         run_vector(i, vec_q[i]);
      end
      if (vec_q.size() == 0) begin
         $display("no vectors were read from the vector file");
      end
      $display("vectors run %0d, vectors with mismatches %0d, failed checks %0d",
               vec_q.size(), failed_vectors, error_count);
      if (error_count == 0 && vec_q.size() > 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

   initial begin
      wait (vectors_loaded);
      #(limit_ns);
      $display("timeout, the run did not finish within %0d ns", limit_ns);
      $display("SOME TESTS FAILED");
      $finish;
   end

endmodule

// ==== cft_flag_testdata.txt ====
# mode waddr raddr bus_in alu_result carry overflow alu_we fp_en (stimulus, hex)
# exp_flags(fi fv fl fz fn) exp_drive exp_ibus_hi exp_write_ir exp_read_agl (expected, hex)
step 00 00 0000 0000 0 0 0 1 00 0 00 0 0
step 0d 0d b000 0000 0 0 1 1 1c 1 b0 0 0
run  00 0e 0000 0000 0 0 1 1 12 1 88 0 0
step 00 0f 0000 8001 1 0 1 0 15 0 00 0 1
run  0e 0d 2000 0000 1 1 1 1 09 1 24 0 0
run  0f 00 1234 7fff 0 1 1 1 08 0 00 1 0
step 1d 1e ffff 0000 0 0 0 1 08 0 00 0 0
step 05 07 ffff 0000 0 0 0 1 08 0 00 0 0
run  0d 0e ffff 0000 0 0 0 1 1c 1 b0 0 0
step 00 0d 0000 0000 1 1 1 1 1e 1 b8 0 0
step 0c 0c 0000 c000 0 0 1 0 11 0 00 0 0
run  0e 0f 0000 0000 0 0 0 1 01 0 00 0 1
run  0f 0e 0000 0001 0 0 0 1 01 1 04 1 0
step 0d 0d a000 8000 1 1 1 1 19 1 a4 0 0

// ==== sources.f ====
cft_pkg.sv
cycle_control_fsm.sv
phase_timer.sv
flag_unit.sv
flag_register.sv
cft_flag_top.sv
tb_cft_flag_top.sv

// ==== Bender.yml ====
package:
  name: cft_flag

sources:
  - cft_pkg.sv
  - cycle_control_fsm.sv
  - phase_timer.sv
  - flag_unit.sv
  - flag_register.sv
  - cft_flag_top.sv
  - target: simulation
    files:
      - tb_cft_flag_top.sv
